// ==== bench/neander_checker.sv ====
`timescale 1ns/100ps
`include "neander_cfg.svh"

module neander_checker (
    input logic               clk,
    input logic               reset,
    input core_pkg::mem_req_t mem_req,
    input logic               halted
);
    import isa_pkg::*;

    // One expected memory write
    typedef struct packed {
        byte_t addr;
        byte_t data;
    } store_t;

    store_t expected [$];       // Writes still to come, program order
    store_t head;
    int     err_count   = 0;
    int     store_count = 0;
    logic   first_read  = 1'b1;  // No fetch seen since reset
    logic   halt_seen   = 1'b0;  // Halted in the previous cycle

    task automatic clear_expected();
        expected.delete();
    endtask

    task automatic expect_store(input byte_t addr, input byte_t data);
        expected.push_back(store_t'{addr: addr, data: data});
    endtask

    // --------------------
    // Bus monitor
    // --------------------
    always @(posedge clk) begin
        if (reset) begin
            if (mem_req.re || mem_req.we || halted) begin
                $display("Fail at %0t: memory request or halt while in reset", $time);
                err_count++;
            end
            first_read <= 1'b1;
            halt_seen  <= 1'b0;
        end else begin
            if (first_read && mem_req.we) begin     // Nothing may be written before the fetch
                $display("Fail at %0t: write before the first fetch", $time);
                err_count++;
            end
            if (first_read && mem_req.re) begin
                first_read <= 1'b0;
                if (mem_req.addr != byte_t'(`NEANDER_RESET_PC)) begin
                    $display("Fail at %0t: first fetch from %02h, expected %02h", $time,
                             mem_req.addr, byte_t'(`NEANDER_RESET_PC));
                    err_count++;
                end
            end
            if (mem_req.we) begin
                store_count++;
                if (expected.size() == 0) begin
                    $display("Fail at %0t: unexpected write of %02h to %02h", $time,
                             mem_req.wdata, mem_req.addr);
                    err_count++;
                end else begin
                    head = expected.pop_front();
                    if (mem_req.addr != head.addr || mem_req.wdata != head.data) begin
                        $display("Fail at %0t: write %02h to %02h, expected %02h to %02h",
                                 $time, mem_req.wdata, mem_req.addr, head.data, head.addr);
                        err_count++;
                    end
                end
            end
            if (halted && !halt_seen && expected.size() != 0) begin   // Halt came too early
                $display("Fail at %0t: halted with %0d writes missing", $time, expected.size());
                err_count++;
            end
            if (halt_seen && !halted) begin
                $display("Fail at %0t: halted dropped without reset", $time);
                err_count++;
            end
            if (halted && (mem_req.re || mem_req.we)) begin
                $display("Fail at %0t: memory request while halted", $time);
                err_count++;
            end
            halt_seen <= halted;
        end
    end

endmodule

// ==== bench/neander_tb.sv ====
`timescale 1ns/100ps

module neander_tb;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int NUM_PROGRAMS = 20;
    localparam int TIMEOUT      = 5000;     // Cycles per wait
    localparam int STEP_LIMIT   = 600;      // Model instructions before a program is dropped
    localparam int QUIET_CYCLES = 50;

    logic        clk       = 1'b0;
    logic        reset     = 1'b1;
    logic        load_ram  = 1'b0;          // Copies prog into the RAM model
    byte_t       mem_rdata = '0;
    mem_req_t    mem_req;
    logic        halted;
    byte_t       ram [256];
    byte_t       prog [256];                // Image of the current program
    byte_t       exp_addr [$];
    byte_t       exp_data [$];
    logic [31:0] lfsr      = 32'd69712;
    int          errors    = 0;
    int          steps;
    int          cycles;
    logic        aborted   = 1'b0;
    logic        ok;

    neander_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .halted    (halted)
    );

    neander_checker checker_i (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .halted  (halted)
    );

    always #50 clk = ~clk;                  // 100 ns period

    // RAM model, one cycle read latency
    always @(posedge clk) begin
        if (load_ram) begin
            ram <= prog;
        end else begin
            if (mem_req.we)
                ram[mem_req.addr] <= mem_req.wdata;
            if (mem_req.re)
                mem_rdata <= ram[mem_req.addr];
        end
    end

    // --------------------
    // Random source
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // Taps 32, 22, 2, 1
    endfunction

    task automatic draw(input int n, output byte_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    // STA to AND, LDX, JMP, JN and JZ carry an operand byte
    function automatic logic is_two_byte(input logic [3:0] op);
        return (op >= 4'h1 && op <= 4'h5) || (op >= 4'h7 && op <= 4'hA);
    endfunction

    // --------------------
    // Program generator
    // --------------------
    task automatic build_program();
        byte_t starts [$];      // Instruction start addresses
        byte_t jumps [$];       // Operand addresses of jumps
        byte_t a;
        byte_t op;
        byte_t sub;
        byte_t r;
        logic  two;
        int    k;
        for (int i = 128; i < 256; i++)
            draw(8, prog[byte_t'(i)]);              // Random data region
        a = '0;
        while (a < 8'd120) begin
            draw(4, op);
            draw(4, sub);
            if (op == 8'h0F)
                op = 8'h0E;                         // No early halt
            two = is_two_byte(op[3:0]);
            if (two && a == 8'd119) begin           // Last slot takes a one-byte op
                op  = 8'h00;
                two = 1'b0;
            end
            prog[a] = {op[3:0], sub[3:0]};
            starts.push_back(a);
            if (two) begin
                draw(7, r);
                if (op inside {8'h08, 8'h09, 8'h0A})
                    jumps.push_back(a + 8'd1);      // Target set below
                prog[a + 8'd1] = (op == 8'h07) ? r : (r | 8'h80);
            end
            a = a + (two ? 8'd2 : 8'd1);
        end
        // Epilogue makes AC and X visible
        prog[120] = 8'h10;
        prog[121] = 8'hFE;
        prog[122] = 8'hD0;
        prog[123] = 8'h10;
        prog[124] = 8'hFF;
        for (int i = 125; i < 128; i++)
            prog[byte_t'(i)] = 8'hF0;
        starts.push_back(8'd120);
        foreach (jumps[j]) begin                    // Forward, onto an instruction start
            k = 0;
            while (starts[k] <= jumps[j])
                k++;
            draw(3, r);
            k = k + int'(r);
            if (k >= starts.size())
                k = starts.size() - 1;
            prog[jumps[j]] = starts[k];
        end
    endtask

    // --------------------
    // ISA reference model
    // --------------------
    task automatic run_model(output logic halt_ok);
        byte_t m [256];
        byte_t pc;
        byte_t ac;
        byte_t x;
        byte_t ins;
        byte_t opnd;
        byte_t ea;
        logic  n;
        logic  z;
        m       = prog;
        pc      = '0;
        ac      = '0;
        x       = '0;
        n       = 1'b0;
        z       = 1'b1;                             // Flags of AC after reset
        halt_ok = 1'b0;
        steps   = 0;
        exp_addr.delete();
        exp_data.delete();
        while (!halt_ok && steps < STEP_LIMIT) begin
            ins  = m[pc];
            pc   = pc + 8'd1;
            opnd = '0;
            steps++;
            if (is_two_byte(ins[7:4])) begin
                opnd = m[pc];
                pc   = pc + 8'd1;
            end
            ea = (ins[0] && ins[7:4] >= 4'h1 && ins[7:4] <= 4'h5) ? opnd + x : opnd;
            case (ins[7:4])
                4'h1: begin
                    m[ea] = ac;
                    exp_addr.push_back(ea);
                    exp_data.push_back(ac);
                end
                4'h2: ac = m[ea];
                4'h3: ac = ac + m[ea];              // Wraps
                4'h4: ac = ac | m[ea];
                4'h5: ac = ac & m[ea];
                4'h6: ac = ~ac;
                4'h7: x = opnd;
                4'h8: pc = opnd;
                4'h9: if (n) pc = opnd;
                4'hA: if (z) pc = opnd;
                4'hB: x = x + 8'd1;
                4'hC: x = ac;
                4'hD: ac = x;
                4'hF: halt_ok = 1'b1;
                default: ;                          // NOP and code E
            endcase
            if (ins[7:4] inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hD}) begin
                n = ac[7];
                z = (ac == 8'd0);
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        for (int p = 0; p < NUM_PROGRAMS && !aborted; p++) begin
            @(posedge clk);
            reset    <= 1'b1;
            load_ram <= 1'b1;
            ok = 1'b0;
            for (int t = 0; t < 50 && !ok; t++) begin   // Drop programs that never halt
                build_program();
                run_model(ok);
            end
            if (!ok) begin
                $display("Program %0d could not be made to halt in %0d steps", p, STEP_LIMIT);
                errors++;
                aborted = 1'b1;
            end else begin
                checker_i.clear_expected();
                foreach (exp_addr[i])
                    checker_i.expect_store(exp_addr[i], exp_data[i]);
                @(posedge clk);
                load_ram <= 1'b0;
                repeat (2) @(posedge clk);
                reset <= 1'b0;                          // Held 3 cycles
                cycles = 0;
                while (!halted && cycles < TIMEOUT) begin
                    @(negedge clk);
                    cycles++;
                end
                if (!halted) begin
                    $display("Timeout: program %0d did not halt within %0d cycles", p, TIMEOUT);
                    errors++;
                    aborted = 1'b1;
                end else begin
                    $display("Program %0d: %0d instructions, %0d stores, %0d cycles", p, steps,
                             exp_addr.size(), cycles);
                    repeat (QUIET_CYCLES) @(negedge clk);   // Checker watches the bus
                end
            end
        end
        $display("Error counts: checker %0d, testbench %0d, writes seen %0d",
                 checker_i.err_count, errors, checker_i.store_count);
        if (errors == 0 && checker_i.err_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== common/core_pkg.sv ====
`include "neander_cfg.svh"

package core_pkg;

    // --------------------
    // ALU operations
    // --------------------
    typedef enum logic [2:0] {
        ALU_PASS_B     = 3'd0,      // Memory data straight through, LDA
        ALU_ADD        = 3'd1,
        ALU_OR         = 3'd2,
        ALU_AND        = 3'd3,
        ALU_NOT_A      = 3'd4,      // Complement of AC
        ALU_INC_X_PASS = 3'd5,      // AC held while X counts up
        ALU_PASS_X     = 3'd6       // TXA
    } alu_op_e;

    // --------------------
    // Control word, one per cycle
    // --------------------
    typedef struct packed {
        logic    pc_inc;
        logic    pc_load;           // PC from memory data, jumps
        logic    rem_load;
        logic    rem_from_pc;       // Else REM from RDM
        logic    rdm_load;
        logic    ri_load;
        logic    x_load;
        logic    x_from_ac;         // Else X from memory data
        logic    x_inc;
        logic    index_en;          // Address is REM plus X
        logic    ac_load;
        logic    nz_load;
        alu_op_e alu_op;
    } ctrl_t;

    // Datapath state seen by the FSM
    typedef struct packed {
        isa_pkg::instr_t instr;
        logic            flag_n;
        logic            flag_z;
    } status_t;

    // Memory port, read data returns one cycle after re
    typedef struct packed {
        logic [`NEANDER_ADDR_W-1:0] addr;
        isa_pkg::byte_t             wdata;
        logic                       we;
        logic                       re;
    } mem_req_t;

endpackage

// ==== common/isa_pkg.sv ====
`include "neander_cfg.svh"

package isa_pkg;

    // One data word
    typedef logic [`NEANDER_DATA_W-1:0] byte_t;

    // --------------------
    // Opcodes, upper nibble of the instruction byte
    // --------------------
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,
        OP_STA = 4'h1,              // Store AC
        OP_LDA = 4'h2,
        OP_ADD = 4'h3,              // Wraps mod 256
        OP_OR  = 4'h4,
        OP_AND = 4'h5,
        OP_NOT = 4'h6,              // Operates on AC only
        OP_LDX = 4'h7,              // X from operand byte
        OP_JMP = 4'h8,
        OP_JN  = 4'h9,
        OP_JZ  = 4'hA,
        OP_INX = 4'hB,
        OP_TAX = 4'hC,
        OP_TXA = 4'hD,
        OP_HLT = `NEANDER_HLT_OP    // Code E is left unnamed, runs as NOP
    } opcode_e;

    // Instruction byte layout
    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] sub;            // Bit 0 selects indexing by X
    } instr_t;

    // Position of the index flag in sub
    localparam int unsigned IDX_BIT = 0;

    // Two-byte instructions, the second byte is an address or jump target
    function automatic logic has_operand(opcode_e op);
        return op inside {OP_STA, OP_LDA, OP_ADD, OP_OR, OP_AND,
                          OP_LDX, OP_JMP, OP_JN, OP_JZ};
    endfunction

endpackage

// ==== common/neander_cfg.svh ====
`ifndef NEANDER_CFG_SVH
`define NEANDER_CFG_SVH

// --------------------
// Core widths
// --------------------

// Data word width
`define NEANDER_DATA_W 8

// Memory address width, 256 bytes
`define NEANDER_ADDR_W 8

// --------------------
// Start-up and special encodings
// --------------------

// First fetch address after reset
`define NEANDER_RESET_PC 'h00

// Opcode nibble that stops the core
`define NEANDER_HLT_OP 4'hF

`endif

// ==== datapath/accum_unit.sv ====
`timescale 1ns/100ps

module accum_unit (
    input  logic            clk,
    input  logic            reset,
    input  core_pkg::ctrl_t ctrl,
    input  isa_pkg::byte_t  mem_rdata,
    input  isa_pkg::byte_t  x,
    output isa_pkg::byte_t  ac,
    output logic            flag_n,
    output logic            flag_z
);
    import isa_pkg::*;
    import core_pkg::*;

    byte_t alu_b;       // Second ALU operand
    byte_t alu_res;     // AC input

    // --------------------
    // Operand select
    // --------------------
    // X only for TXA, memory data otherwise
    assign alu_b = (ctrl.alu_op == ALU_PASS_X) ? x : mem_rdata;

    // --------------------
    // ALU
    // --------------------
    always_comb begin
        case (ctrl.alu_op)
            ALU_PASS_B,
            ALU_PASS_X: alu_res = alu_b;
            ALU_ADD:    alu_res = ac + alu_b;   // Carry dropped
            ALU_OR:     alu_res = ac | alu_b;
            ALU_AND:    alu_res = ac & alu_b;
            ALU_NOT_A:  alu_res = ~ac;
            default:    alu_res = ac;           // INX and spare code keep AC
        endcase
    end

    // --------------------
    // Accumulator and flags
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ac     <= '0;
            flag_n <= 1'b0;
            flag_z <= 1'b1;                     // Matches AC of zero
        end else begin
            if (ctrl.ac_load)
                ac <= alu_res;
            if (ctrl.nz_load) begin
                flag_n <= alu_res[$bits(byte_t)-1];     // Sign of loaded value
                flag_z <= (alu_res == '0);
            end
        end
    end

endmodule

// ==== datapath/address_unit.sv ====
`timescale 1ns/100ps
`include "neander_cfg.svh"

module address_unit (
    input  logic            clk,
    input  logic            reset,
    input  core_pkg::ctrl_t ctrl,
    input  isa_pkg::byte_t  mem_rdata,
    input  isa_pkg::byte_t  ac,
    output isa_pkg::instr_t instr,
    output isa_pkg::byte_t  mem_addr,
    output isa_pkg::byte_t  x
);
    import isa_pkg::*;

    byte_t  pc;
    byte_t  rem;        // Memory address register
    byte_t  rdm;        // Memory data register, operand address
    instr_t ri;
    byte_t  rem_in;
    byte_t  x_in;

    assign instr  = ri;
    assign rem_in = ctrl.rem_from_pc ? pc : rdm;
    assign x_in   = ctrl.x_from_ac ? ac : mem_rdata;   // TAX or LDX

    // Effective address, sum wraps at 256
    assign mem_addr = ctrl.index_en ? byte_t'(rem + x) : rem;

    // --------------------
    // Program counter
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= byte_t'(`NEANDER_RESET_PC);
        else if (ctrl.pc_load)
            pc <= mem_rdata;            // Jump target straight from memory
        else if (ctrl.pc_inc)
            pc <= pc + byte_t'(1);
    end

    // --------------------
    // REM, RI and X
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rem <= '0;
            ri  <= '0;                  // NOP, nothing to finish in the first ADDR
            x   <= '0;
        end else begin
            if (ctrl.rem_load)
                rem <= rem_in;
            if (ctrl.ri_load)
                ri <= instr_t'(mem_rdata);
            if (ctrl.x_load)
                x <= x_in;
            else if (ctrl.x_inc)
                x <= x + byte_t'(1);    // INX
        end
    end

    // Operand register
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            rdm <= '0;
        else if (ctrl.rdm_load)
            rdm <= mem_rdata;
    end

    // Sequencer never loads and counts PC in one cycle
    a_pc_strobes: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.pc_load && ctrl.pc_inc));

endmodule

// ==== hw/control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::status_t status,
    output core_pkg::ctrl_t   ctrl,
    output logic              mem_re,
    output logic              mem_we,
    output logic              halted
);
    import isa_pkg::*;
    import core_pkg::*;

    // One cycle per state
    typedef enum logic [3:0] {
        S_ADDR,         // REM from PC, finishes memory ALU ops
        S_READ,         // Instruction read
        S_LOAD_RI,      // RI from memory, REM from PC
        S_OP_READ,      // Operand read, or run a one-byte op and read the next one
        S_OP_LOAD,      // Operand into RDM, X or PC
        S_EA_ADDR,      // REM from RDM
        S_EXEC_READ,
        S_EXEC_WRITE,
        S_HALT
    } state_e;

    state_e  state;
    state_e  state_nxt;
    opcode_e op;
    logic    alu_mem_op;    // LDA, ADD, OR, AND
    logic    mem_op;        // Above plus STA
    logic    indexed;
    logic    jump_taken;
    alu_op_e alu_sel;

    assign op         = status.instr.opcode;
    assign alu_mem_op = op inside {OP_LDA, OP_ADD, OP_OR, OP_AND};
    assign mem_op     = alu_mem_op || (op == OP_STA);
    assign indexed    = mem_op && status.instr.sub[IDX_BIT];   // Ignored elsewhere
    assign halted     = (state == S_HALT);

    // --------------------
    // Decode
    // --------------------
    always_comb begin
        case (op)
            OP_JMP:  jump_taken = 1'b1;
            OP_JN:   jump_taken = status.flag_n;
            OP_JZ:   jump_taken = status.flag_z;
            default: jump_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            OP_ADD:  alu_sel = ALU_ADD;
            OP_OR:   alu_sel = ALU_OR;
            OP_AND:  alu_sel = ALU_AND;
            OP_NOT:  alu_sel = ALU_NOT_A;
            OP_INX:  alu_sel = ALU_INC_X_PASS;
            OP_TXA:  alu_sel = ALU_PASS_X;
            default: alu_sel = ALU_PASS_B;  // LDA
        endcase
    end

    // --------------------
    // Sequencer
    // --------------------
    always_comb begin
        ctrl      = '0;
        mem_re    = 1'b0;
        mem_we    = 1'b0;
        state_nxt = state;
        case (state)
            S_ADDR: begin
                ctrl.rem_load    = 1'b1;
                ctrl.rem_from_pc = 1'b1;
                if (alu_mem_op) begin       // Data from EXEC_READ is on the bus now
                    ctrl.ac_load = 1'b1;
                    ctrl.nz_load = 1'b1;
                    ctrl.alu_op  = alu_sel;
                end
                state_nxt = S_READ;
            end
            S_READ: begin
                mem_re      = 1'b1;
                ctrl.pc_inc = 1'b1;
                state_nxt   = S_LOAD_RI;
            end
            S_LOAD_RI: begin
                ctrl.ri_load     = 1'b1;
                ctrl.rem_load    = 1'b1;    // Operand or next instruction address
                ctrl.rem_from_pc = 1'b1;
                state_nxt        = S_OP_READ;
            end
            S_OP_READ: begin
                if (op == OP_HLT) begin
                    state_nxt = S_HALT;
                end else begin
                    mem_re      = 1'b1;
                    ctrl.pc_inc = 1'b1;
                    if (has_operand(op)) begin
                        state_nxt = S_OP_LOAD;
                    end else begin
                        // One-byte op runs here, the read fetches what follows
                        case (op)
                            OP_NOT, OP_TXA: begin
                                ctrl.ac_load = 1'b1;
                                ctrl.nz_load = 1'b1;
                                ctrl.alu_op  = alu_sel;
                            end
                            OP_INX: begin
                                ctrl.x_inc  = 1'b1;
                                ctrl.alu_op = alu_sel;
                            end
                            OP_TAX: begin
                                ctrl.x_load    = 1'b1;
                                ctrl.x_from_ac = 1'b1;
                            end
                            default: ;              // NOP and code E
                        endcase
                        state_nxt = S_LOAD_RI;
                    end
                end
            end
            S_OP_LOAD: begin
                if (mem_op) begin
                    ctrl.rdm_load = 1'b1;
                    state_nxt     = S_EA_ADDR;
                end else begin
                    ctrl.x_load  = (op == OP_LDX);
                    ctrl.pc_load = jump_taken;
                    state_nxt    = S_ADDR;
                end
            end
            S_EA_ADDR: begin
                ctrl.rem_load = 1'b1;               // Operand address from RDM
                state_nxt     = (op == OP_STA) ? S_EXEC_WRITE : S_EXEC_READ;
            end
            S_EXEC_READ: begin
                mem_re        = 1'b1;
                ctrl.index_en = indexed;
                state_nxt     = S_ADDR;
            end
            S_EXEC_WRITE: begin
                mem_we        = 1'b1;
                ctrl.index_en = indexed;
                state_nxt     = S_ADDR;
            end
            default: state_nxt = S_HALT;            // Held until reset
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= S_ADDR;
        else
            state <= state_nxt;
    end

    // Single memory port
    a_re_we_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_re && mem_we));

    // Halt is sticky and the core stays quiet
    a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted && (ctrl == '0) && !mem_re && !mem_we);

endmodule

// ==== hw/neander_top.sv ====
`timescale 1ns/100ps

module neander_top (
    input  logic               clk,
    input  logic               reset,
    input  isa_pkg::byte_t     mem_rdata,
    output core_pkg::mem_req_t mem_req,
    output logic               halted
);
    import isa_pkg::*;
    import core_pkg::*;

    ctrl_t   ctrl;          // Shared by both datapath units
    status_t status;
    instr_t  instr;
    byte_t   ac;
    byte_t   x;
    byte_t   mem_addr;
    logic    flag_n;
    logic    flag_z;
    logic    mem_re;
    logic    mem_we;

    // Status toward the FSM
    assign status = status_t'{instr: instr, flag_n: flag_n, flag_z: flag_z};

    // Memory request, address and data from the datapath, strobes from control
    assign mem_req = mem_req_t'{addr: mem_addr, wdata: ac, we: mem_we, re: mem_re};

    // --------------------
    // Control
    // --------------------
    control_unit control_i (
        .clk    (clk),
        .reset  (reset),
        .status (status),
        .ctrl   (ctrl),
        .mem_re (mem_re),
        .mem_we (mem_we),
        .halted (halted)
    );

    // --------------------
    // Datapath
    // --------------------
    address_unit address_i (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .ac        (ac),            // TAX source
        .instr     (instr),
        .mem_addr  (mem_addr),
        .x         (x)
    );

    accum_unit accum_i (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .x         (x),             // TXA source
        .ac        (ac),
        .flag_n    (flag_n),
        .flag_z    (flag_z)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f verilog.f --top-module neander_tb &&
./obj_dir/Vneander_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation result: pass" ||
{ echo "Simulation result: fail"; exit 1; }

// ==== verilog.f ====
+incdir+common
common/isa_pkg.sv
common/core_pkg.sv
datapath/address_unit.sv
datapath/accum_unit.sv
hw/control_unit.sv
hw/neander_top.sv
bench/neander_checker.sv
bench/neander_tb.sv
